// File: files.f
+incdir+sim
src/mipsPkg.sv
src/instrDecode.sv
src/controlSequencer.sv
src/regFile.sv
src/aluUnit.sv
src/busControl.sv
src/mipsCpuBus.sv
sim/tbMipsCpu.sv

// File: sim/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] modelMem [0:1023];
logic [31:0] modelRegs [0:31];
logic [31:0] expReads [$];
busReqT      expStores [$];
logic        modelHalted;
int          modelSteps;

// Instruction-level run of the subset, one delay slot after each taken transfer
task automatic runModel(input logic [31:0] startPc);
    logic [31:0] pc;
    logic [31:0] pc4;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] target;
    logic [31:0] savedTarget;
    logic [4:0]  dest;
    logic        pending;
    logic        taken;
    logic        wr;
    pc = startPc;
    pending = 1'b0;
    savedTarget = '0;
    modelSteps = 0;
    expReads.delete();
    expStores.delete();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    while (pc != '0 && modelSteps < 5000) begin
        expReads.push_back(pc);
        instr = modelMem[pc[11:2]];
        pc4 = pc + 32'd4;
        a = modelRegs[instr[25:21]];
        b = modelRegs[instr[20:16]];
        sImm = {{16{instr[15]}}, instr[15:0]};
        ea = a + sImm;
        target = pc4 + (sImm << 2);
        dest = instr[20:16];
        res = '0;
        wr = 1'b1;
        taken = 1'b0;
        case (opcodeT'(instr[31:26]))
            opR: begin
                dest = instr[15:11];
                case (funcT'(instr[5:0]))
                    fnAddu: res = a + b;
                    fnSubu: res = a - b;
                    fnAnd:  res = a & b;
                    fnOr:   res = a | b;
                    fnXor:  res = a ^ b;
                    fnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                    fnSltu: res = {31'b0, a < b};
                    fnSll:  res = b << instr[10:6];
                    fnSrl:  res = b >> instr[10:6];
                    fnSra:  res = $signed(b) >>> instr[10:6];
                    fnSllv: res = b << a[4:0];
                    fnSrlv: res = b >> a[4:0];
                    fnSrav: res = $signed(b) >>> a[4:0];
                    fnJr: begin
                        wr = 1'b0;
                        taken = 1'b1;
                        target = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            opAddiu: res = ea;
            opAndi:  res = a & {16'h0, instr[15:0]};
            opOri:   res = a | {16'h0, instr[15:0]};
            opXori:  res = a ^ {16'h0, instr[15:0]};
            opSlti:  res = {31'b0, $signed(a) < $signed(sImm)};
            opSltiu: res = {31'b0, a < sImm};
            opLui:   res = {instr[15:0], 16'h0};
            opLw: begin
                expReads.push_back(ea);
                res = modelMem[ea[11:2]];
            end
            opSw: begin
                wr = 1'b0;
                // Word store, all byte lanes
                expStores.push_back({ea, 1'b0, 1'b1, b, 4'hf});
                modelMem[ea[11:2]] = b;
            end
            opBeq: begin
                wr = 1'b0;
                taken = (a == b);
            end
            opBne: begin
                wr = 1'b0;
                taken = (a != b);
            end
            opJ: begin
                wr = 1'b0;
                taken = 1'b1;
                target = {pc4[31:28], instr[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            modelRegs[dest] = res;
        end
        pc = pending ? savedTarget : pc4;
        pending = taken;
        if (taken) begin
            savedTarget = target;
        end
        modelSteps++;
    end
    modelHalted = (pc == '0);
endtask

`endif

// File: sim/tbMipsCpu.sv
`timescale 1ns/1ps

module tbMipsCpu;
    import mipsPkg::*;

    localparam logic [31:0] progBase = 32'h0000_0400;
    localparam logic [31:0] dataBase = 32'h0000_0800;
    localparam int maxWait = 3;
    localparam int numProgs = 4;

    logic        clk;
    logic        rst;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] image [0:1023];
    logic [31:0] mem [0:1023];
    logic [31:0] gotReads [$];
    busReqT      gotStores [$];
    funcT        rFuncs [0:12] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu,
                                   fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
    opcodeT      iOps [0:6] = '{opAddiu, opAndi, opOri, opXori, opSlti, opSltiu, opLui};
    integer      seed;
    int          emitAt;
    int          errCount;
    int          checkCount;
    int          waitRun;
    bit          waitsOn;
    logic        prevActive;
    logic        prevFetchZero;

    `include "isaModel.svh"

    mipsCpuBus #(.resetVector(progBase)) uut (
        .clk(clk), .rst(rst), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    // Zero-latency memory, data valid whenever the address is
    assign readdata = mem[address[11:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        // Random stalls, at most maxWait in a row
        if (waitsOn && waitRun < maxWait && $random(seed) % 2 != 0) begin
            waitrequest <= 1'b1;
            waitRun <= waitRun + 1;
        end else begin
            waitrequest <= 1'b0;
            waitRun <= 0;
        end
        if (!rst) begin
            if (read && !waitrequest && address != '0) begin
                gotReads.push_back(address);
            end
            if (write && !waitrequest) begin
                gotStores.push_back({address, read, write, writedata, byteenable});
                mem[address[11:2]] <= writedata;
            end
            if (read && byteenable != 4'hf) begin
                checkWord("byteenable", {28'h0, byteenable}, 32'hf);
            end
            if (!active && (read || write)) begin
                errCount++;
                $display("Bus access at address %h after the CPU halted", address);
            end
            if (prevActive && !active) begin
                checkFlag("read at address 0 before halt", prevFetchZero, 1'b1);
            end
        end
        prevActive <= rst ? 1'b1 : active;
        prevFetchZero <= read && address == '0;
    end

    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkStore(input int n, input busReqT got, input busReqT exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR address/writedata/byteenable store %0d got %h/%h/%h expected %h/%h/%h",
                     n, got.address, got.writedata, got.byteenable,
                     exp.address, exp.writedata, exp.byteenable);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int pick(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] rIns(input funcT fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
        return {opR, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iIns(input opcodeT op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        image[emitAt] = word;
        emitAt++;
    endtask

    // Anything but a branch or jump; r1 is the data base, r30 the jump register
    task automatic emitPlain();
        logic [4:0] rd;
        rd = 5'(3 + pick(27));
        case (pick(4))
            0: emit(rIns(rFuncs[pick(13)], 5'(pick(32)), 5'(pick(32)), rd, 5'(pick(32))));
            1: emit(iIns(iOps[pick(7)], 5'(pick(32)), rd, 16'(pick(65536))));
            2: emit(iIns(opLw, 5'd1, rd, 16'(4 * pick(64))));
            default: emit(iIns(opSw, 5'd1, 5'(pick(32)), 16'(4 * pick(64))));
        endcase
    endtask

    task automatic genProgram(output int words);
        int n;
        int kind;
        logic [31:0] target;
        logic [4:0]  rs;
        for (int i = 0; i < 1024; i++) begin
            image[i] = fillWord(i * 4);
        end
        emitAt = progBase >> 2;
        emit(iIns(opOri, 5'd0, 5'd1, dataBase[15:0]));
        for (int r = 3; r < 30; r++) begin
            emit(iIns(opLui, 5'd0, 5'(r), 16'(pick(65536))));
            emit(iIns(opOri, 5'(r), 5'(r), 16'(pick(65536))));
        end
        for (int blk = 0; blk < 25; blk++) begin
            kind = pick(6);
            n = 1 + pick(3);
            if (kind < 3) begin
                emitPlain();
            end else begin
                // Forward transfer over the delay slot plus n-1 instructions
                if (kind == 3) begin
                    rs = 5'(pick(32));
                    emit(iIns(pick(2) ? opBeq : opBne, rs, pick(2) ? rs : 5'(pick(32)),
                              16'(n)));
                end else if (kind == 4) begin
                    target = (emitAt + 2 + n) * 4;
                    emit(iIns(opOri, 5'd0, 5'd30, target[15:0]));
                    emit(rIns(fnJr, 5'd30, 5'd0, 5'd0, 5'd0));
                end else begin
                    target = (emitAt + 1 + n) * 4;
                    emit({opJ, 26'(target >> 2)});
                end
                for (int k = 0; k < n; k++) begin
                    emitPlain();
                end
            end
        end
        // Checksum of all registers into v0, then jump to zero
        for (int r = 1; r < 32; r++) begin
            if (r != 2) begin
                emit(rIns(fnXor, 5'd2, 5'(r), 5'd2, 5'd0));
            end
        end
        emit(rIns(fnJr, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'h0);
        words = emitAt - (progBase >> 2);
    endtask

    task automatic runProgram(input int progNo, input int words, input bit withWaits,
                              output bit timedOut);
        int errBefore;
        int mark;
        int cycles;
        int limit;
        errBefore = errCount;
        limit = words * 5 * (maxWait + 1) + 100;
        waitsOn = withWaits;
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        for (int i = 0; i < 1024; i++) begin
            mem[i] = image[i];
        end
        gotReads.delete();
        gotStores.delete();
        rst <= 1'b0;
        @(negedge clk);
        checkWord("address", address, progBase);
        checkFlag("read", read, 1'b1);
        checkFlag("write", write, 1'b0);
        cycles = 0;
        while (active && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        timedOut = active;
        if (timedOut) begin
            $display("Program %0d did not halt within %0d cycles", progNo, limit);
        end else begin
            repeat (4) @(negedge clk);
            if (gotReads.size() != expReads.size() || gotStores.size() != expStores.size()) begin
                errCount++;
                $display("Program %0d made %0d reads and %0d stores, model made %0d and %0d",
                         progNo, gotReads.size(), gotStores.size(),
                         expReads.size(), expStores.size());
            end
            mark = errCount;
            for (int i = 0; i < gotReads.size() && i < expReads.size() && errCount == mark;
                 i++) begin
                checkWord($sformatf("address of read %0d", i), gotReads[i], expReads[i]);
            end
            mark = errCount;
            for (int i = 0; i < gotStores.size() && i < expStores.size() && errCount == mark;
                 i++) begin
                checkStore(i, gotStores[i], expStores[i]);
            end
            checkWord("registerV0", registerV0, modelRegs[2]);
        end
        $display("Program %0d, wait states %s: %0d instructions, %0d cycles, %0d errors",
                 progNo, withWaits ? "on" : "off", modelSteps, cycles, errCount - errBefore);
    endtask

    initial begin
        int words;
        bit timedOut;
        seed = 32'hcc29;
        rst = 1'b1;
        waitrequest = 1'b0;
        waitsOn = 1'b0;
        waitRun = 0;
        errCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        for (int p = 0; p < numProgs && !timedOut; p++) begin
            genProgram(words);
            for (int i = 0; i < 1024; i++) begin
                modelMem[i] = image[i];
            end
            runModel(progBase);
            if (!modelHalted) begin
                errCount++;
                $display("Model of program %0d never reached address zero", p);
            end
            runProgram(p, words, 1'b0, timedOut);
            if (!timedOut) begin
                runProgram(p, words, 1'b1, timedOut);
            end
        end
        $display("Checks run %0d, errors %0d", checkCount, errCount);
        if (timedOut || errCount != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: src/mipsCpuBus.sv
`timescale 1ns/1ps

module mipsCpuBus #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = 32'hBFC00000
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic                           active,
    output logic [mipsPkg::dataWidth-1:0]  registerV0,
    // Avalon master
    output logic [mipsPkg::dataWidth-1:0]  address,
    output logic                           write,
    output logic                           read,
    input  logic                           waitrequest,
    output logic [mipsPkg::dataWidth-1:0]  writedata,
    output logic [3:0]                     byteenable,
    input  logic [mipsPkg::dataWidth-1:0]  readdata
);
    import mipsPkg::*;

    cpuStateT             state;
    decodedInstrT         dec;
    busReqT               req;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic [dataWidth-1:0] aluResult;
    logic                 aluZero;
    logic                 regWe;
    logic                 busDone;

    instrDecode decodeInst (
        .clk(clk), .rst(rst), .state(state), .readdata(readdata), .dec(dec)
    );

    controlSequencer #(.resetVector(resetVector)) seqInst (
        .clk(clk), .rst(rst), .dec(dec), .aluZero(aluZero), .rsData(rsData),
        .busDone(busDone), .state(state), .pc(pc), .regWe(regWe), .active(active)
    );

    regFile regInst (
        .clk(clk), .rst(rst), .state(state), .we(regWe), .dec(dec),
        .readdata(readdata), .aluResult(aluResult),
        .rsData(rsData), .rtData(rtData), .registerV0(registerV0)
    );

    aluUnit aluInst (
        .clk(clk), .state(state), .dec(dec), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .aluZero(aluZero)
    );

    busControl busInst (
        .state(state), .pc(pc), .dec(dec), .aluResult(aluResult), .rtData(rtData),
        .waitrequest(waitrequest), .req(req), .busDone(busDone)
    );

    assign address    = req.address;
    assign read       = req.read;
    assign write      = req.write;
    assign writedata  = req.writedata;
    assign byteenable = req.byteenable;

endmodule

// File: src/busControl.sv
`timescale 1ns/1ps

module busControl (
    input  mipsPkg::cpuStateT             state,
    input  logic [mipsPkg::dataWidth-1:0] pc,
    input  mipsPkg::decodedInstrT         dec,
    input  logic [mipsPkg::dataWidth-1:0] aluResult,
    input  logic [mipsPkg::dataWidth-1:0] rtData,
    input  logic                          waitrequest,
    output mipsPkg::busReqT               req,
    output logic                          busDone
);
    import mipsPkg::*;

    logic isFetch;
    logic isMem;
    logic transfer;

    assign isFetch = (state == stFetch);
    assign isMem   = (state == stMem);

    always_comb begin
        req.read       = isFetch || (isMem && dec.memRead);
        req.write      = isMem && dec.memWrite;
        // Instruction fetch uses pc, data access the computed address
        req.address    = isFetch ? pc : aluResult;
        req.writedata  = rtData;
        // Word accesses only
        req.byteenable = (req.read || req.write) ? '1 : '0;
    end

    assign transfer = req.read || req.write;

    // Mem phase with nothing to move finishes at once
    assign busDone = transfer ? !waitrequest : isMem;

endmodule

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic                          clk,
    input  mipsPkg::cpuStateT             state,
    input  mipsPkg::decodedInstrT         dec,
    input  logic [mipsPkg::dataWidth-1:0] rsData,
    input  logic [mipsPkg::dataWidth-1:0] rtData,
    output logic [mipsPkg::dataWidth-1:0] aluResult,
    output logic                          aluZero
);
    import mipsPkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [4:0]           varShift;

    always_ff @(posedge clk) begin
        if (state == stExec) begin
            opA <= rsData;
            case (dec.immSel)
                immZero: opB <= {{(dataWidth-16){1'b0}}, dec.imm16};
                immSign: opB <= {{(dataWidth-16){dec.imm16[15]}}, dec.imm16};
                default: opB <= rtData;
            endcase
        end
    end

    // Variable shifts take the amount from rs
    assign varShift = opA[4:0];

    always_comb begin
        case (dec.aluOp)
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu: aluResult = {{(dataWidth-1){1'b0}}, opA < opB};
            aluSll:  aluResult = opB << dec.shamt;
            aluSrl:  aluResult = opB >> dec.shamt;
            aluSra:  aluResult = $signed(opB) >>> dec.shamt;
            aluSllv: aluResult = opB << varShift;
            aluSrlv: aluResult = opB >> varShift;
            aluSrav: aluResult = $signed(opB) >>> varShift;
            aluLui:  aluResult = {opB[15:0], 16'h0000};
            default: aluResult = opA;
        endcase
    end

    assign aluZero = (aluResult == '0);

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          rst,
    input  mipsPkg::cpuStateT             state,
    input  logic                          we,
    input  mipsPkg::decodedInstrT         dec,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    input  logic [mipsPkg::dataWidth-1:0] aluResult,
    output logic [mipsPkg::dataWidth-1:0] rsData,
    output logic [mipsPkg::dataWidth-1:0] rtData,
    output logic [mipsPkg::dataWidth-1:0] registerV0
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [0:(1<<regAddrWidth)-1];
    logic [dataWidth-1:0] loadData;
    logic [dataWidth-1:0] wrData;

    // Read data is only valid in the completing mem cycle
    always_ff @(posedge clk) begin
        if (state == stMem) begin
            loadData <= readdata;
        end
    end

    assign wrData = dec.memRead ? loadData : aluResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << regAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (we && dec.destReg != '0) begin
            regs[dec.destReg] <= wrData;
        end
    end

    assign rsData     = (dec.rs == '0) ? '0 : regs[dec.rs];
    assign rtData     = (dec.rt == '0) ? '0 : regs[dec.rt];
    // v0 is r2
    assign registerV0 = regs[2];

endmodule

// File: src/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = 32'hBFC00000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mipsPkg::decodedInstrT         dec,
    input  logic                          aluZero,
    input  logic [mipsPkg::dataWidth-1:0] rsData,
    input  logic                          busDone,
    output mipsPkg::cpuStateT             state,
    output logic [mipsPkg::dataWidth-1:0] pc,
    output logic                          regWe,
    output logic                          active
);
    import mipsPkg::*;

    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] pendingTarget;
    logic                 takeBranch;
    logic                 branchPending;

    assign pcPlus4 = pc + dataWidth'(4);

    // ALU operands hold from exec through writeBack, so aluZero is stable here
    always_comb begin
        takeBranch = dec.isJump || dec.isJr || (dec.isBeq && aluZero) || (dec.isBne && !aluZero);
        if (dec.isJr) begin
            branchTarget = rsData;
        end else if (dec.isJump) begin
            branchTarget = {pcPlus4[dataWidth-1:dataWidth-4], dec.jumpIndex, 2'b00};
        end else begin
            branchTarget = pcPlus4 + {{(dataWidth-18){dec.imm16[15]}}, dec.imm16, 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= stFetch;
            pc            <= resetVector;
            branchPending <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (pc == '0) begin
                        state <= stHalted;
                    end else if (busDone) begin
                        state <= stDecode;
                    end
                end
                stDecode: state <= stExec;
                stExec:   state <= stMem;
                stMem: begin
                    if (busDone) begin
                        state <= stWriteBack;
                    end
                end
                stWriteBack: begin
                    state <= stFetch;
                    // Delay slot done, jump to the target saved one instruction ago
                    if (branchPending) begin
                        pc <= pendingTarget;
                    end else begin
                        pc <= pcPlus4;
                    end
                    branchPending <= takeBranch;
                end
                stHalted: state <= stHalted;
                default:  state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stWriteBack && takeBranch) begin
            pendingTarget <= branchTarget;
        end
    end

    assign regWe  = (state == stWriteBack) && dec.regWrite;
    assign active = (state != stHalted);

endmodule

// File: src/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  logic                          clk,
    input  logic                          rst,
    input  mipsPkg::cpuStateT             state,
    input  logic [mipsPkg::dataWidth-1:0] readdata,
    output mipsPkg::decodedInstrT         dec
);
    import mipsPkg::*;

    logic [dataWidth-1:0] ir;

    // Last fetch cycle is the completing one, so ir is valid from decode on
    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (state == stFetch) begin
            ir <= readdata;
        end
    end

    always_comb begin
        dec           = '0;
        dec.opcode    = opcodeT'(ir[31:26]);
        dec.func      = funcT'(ir[5:0]);
        dec.rs        = ir[25:21];
        dec.rt        = ir[20:16];
        dec.destReg   = ir[20:16];
        dec.shamt     = ir[10:6];
        dec.imm16     = ir[15:0];
        dec.jumpIndex = ir[25:0];
        dec.aluOp     = aluPassA;
        dec.immSel    = immNone;

        case (dec.opcode)
            opR: begin
                dec.destReg  = ir[15:11];
                dec.regWrite = 1'b1;
                case (dec.func)
                    fnAddu: dec.aluOp = aluAdd;
                    fnSubu: dec.aluOp = aluSub;
                    fnAnd:  dec.aluOp = aluAnd;
                    fnOr:   dec.aluOp = aluOr;
                    fnXor:  dec.aluOp = aluXor;
                    fnSlt:  dec.aluOp = aluSlt;
                    fnSltu: dec.aluOp = aluSltu;
                    fnSll:  dec.aluOp = aluSll;
                    fnSrl:  dec.aluOp = aluSrl;
                    fnSra:  dec.aluOp = aluSra;
                    fnSllv: dec.aluOp = aluSllv;
                    fnSrlv: dec.aluOp = aluSrlv;
                    fnSrav: dec.aluOp = aluSrav;
                    fnJr: begin
                        dec.isJr     = 1'b1;
                        dec.regWrite = 1'b0;
                    end
                    default: dec.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                dec.aluOp    = aluAdd;
                dec.immSel   = immSign;
                dec.regWrite = 1'b1;
            end
            opAndi: begin
                dec.aluOp    = aluAnd;
                dec.immSel   = immZero;
                dec.regWrite = 1'b1;
            end
            opOri: begin
                dec.aluOp    = aluOr;
                dec.immSel   = immZero;
                dec.regWrite = 1'b1;
            end
            opXori: begin
                dec.aluOp    = aluXor;
                dec.immSel   = immZero;
                dec.regWrite = 1'b1;
            end
            opSlti: begin
                dec.aluOp    = aluSlt;
                dec.immSel   = immSign;
                dec.regWrite = 1'b1;
            end
            opSltiu: begin
                // Immediate is sign extended, compare is unsigned
                dec.aluOp    = aluSltu;
                dec.immSel   = immSign;
                dec.regWrite = 1'b1;
            end
            opLui: begin
                dec.aluOp    = aluLui;
                dec.immSel   = immZero;
                dec.regWrite = 1'b1;
            end
            opLw: begin
                dec.aluOp    = aluAdd;
                dec.immSel   = immSign;
                dec.memRead  = 1'b1;
                dec.regWrite = 1'b1;
            end
            opSw: begin
                dec.aluOp    = aluAdd;
                dec.immSel   = immSign;
                dec.memWrite = 1'b1;
            end
            opBeq: begin
                dec.aluOp = aluSub;
                dec.isBeq = 1'b1;
            end
            opBne: begin
                dec.aluOp = aluSub;
                dec.isBne = 1'b1;
            end
            opJ:     dec.isJump = 1'b1;
            default: dec.regWrite = 1'b0;
        endcase
    end

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opR     = 6'b000000,
        opJ     = 6'b000010,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opAddiu = 6'b001001,
        opSlti  = 6'b001010,
        opSltiu = 6'b001011,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opXori  = 6'b001110,
        opLui   = 6'b001111,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } funcT;

    typedef enum logic [3:0] {
        aluAnd, aluOr, aluAdd, aluSub, aluSlt, aluSltu, aluXor, aluSll,
        aluSrl, aluSra, aluSllv, aluSrlv, aluSrav, aluLui, aluPassA
    } aluOpT;

    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExec      = 3'd2,
        stMem       = 3'd3,
        stWriteBack = 3'd4,
        stHalted    = 3'd7
    } cpuStateT;

    // Second ALU operand source
    typedef enum logic [1:0] {
        immNone,
        immZero,
        immSign
    } immSelT;

    typedef struct packed {
        opcodeT                  opcode;
        funcT                    func;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] destReg;
        logic [4:0]              shamt;
        logic [15:0]             imm16;
        logic [25:0]             jumpIndex;
        aluOpT                   aluOp;
        immSelT                  immSel;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic                    isBeq;
        logic                    isBne;
        logic                    isJump;
        logic                    isJr;
    } decodedInstrT;

    // Avalon request as seen on the master port
    typedef struct packed {
        logic [dataWidth-1:0]   address;
        logic                   read;
        logic                   write;
        logic [dataWidth-1:0]   writedata;
        logic [dataWidth/8-1:0] byteenable;
    } busReqT;

endpackage
